/* hdl/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // major opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [2:0] F3_ADD  = 3'b000; // also sub
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101; // srl / sra
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    typedef enum logic [1:0] {
        ALU_BRANCH = 2'b00,
        ALU_IMM    = 2'b01,
        ALU_ADD    = 2'b10,
        ALU_REG    = 2'b11
    } alu_mode_t;

    typedef enum logic [1:0] {
        OP1_RS1  = 2'b00,
        OP1_ZERO = 2'b01, // lui
        OP1_PC   = 2'b10  // auipc
    } op1_sel_t;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_u;

endpackage

`default_nettype wire

/* hdl/ctrl_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface ctrl_if import rv_pkg::*; ();

    logic      reg_write;
    logic      imm_data;   // operand 2 from immediate
    alu_mode_t alu_mode;
    logic      mem_to_reg;
    logic      branch;     // unconditional redirect
    logic      wb_pc;      // rd gets pc+4
    logic      cond_b;
    logic      store;
    logic      jalr;
    op1_sel_t  op1_sel;

    modport dec (
        output reg_write, imm_data, alu_mode, mem_to_reg, branch,
        output wb_pc, cond_b, store, jalr, op1_sel
    );

    modport exe (
        input alu_mode, imm_data, op1_sel
    );

    modport seq (
        input branch, cond_b, jalr, wb_pc, mem_to_reg, store, reg_write
    );

endinterface

`default_nettype wire

/* hdl/control.sv */
`timescale 1ns/1ps
`default_nettype none

module control import rv_pkg::*; (
    input  logic [6:0] opcode,
    ctrl_if.dec        ctl
);

    logic lui;
    logic auipc;

    assign ctl.cond_b     = (opcode == OPC_BRANCH);
    assign ctl.store      = (opcode == OPC_STORE);
    assign ctl.mem_to_reg = (opcode == OPC_LOAD);
    assign ctl.jalr       = (opcode == OPC_JALR);
    assign lui            = (opcode == OPC_LUI);
    assign auipc          = (opcode == OPC_AUIPC);
    assign ctl.op1_sel    = op1_sel_t'({auipc, lui});

    always_comb begin
        case (opcode[6:2])
            OPC_OP_IMM[6:2]: ctl.reg_write = 1'b1;
            OPC_OP[6:2]:     ctl.reg_write = 1'b1;
            OPC_JAL[6:2]:    ctl.reg_write = 1'b1;
            OPC_JALR[6:2]:   ctl.reg_write = 1'b1;
            OPC_LOAD[6:2]:   ctl.reg_write = 1'b1;
            OPC_LUI[6:2]:    ctl.reg_write = 1'b1;
            OPC_AUIPC[6:2]:  ctl.reg_write = 1'b1;
            default:         ctl.reg_write = 1'b0;
        endcase
    end

    // jal target comes from imm_gen, not the alu
    always_comb begin
        case (opcode[6:2])
            OPC_OP_IMM[6:2]: ctl.imm_data = 1'b1;
            OPC_LOAD[6:2]:   ctl.imm_data = 1'b1;
            OPC_STORE[6:2]:  ctl.imm_data = 1'b1;
            OPC_JALR[6:2]:   ctl.imm_data = 1'b1;
            OPC_LUI[6:2]:    ctl.imm_data = 1'b1;
            OPC_AUIPC[6:2]:  ctl.imm_data = 1'b1;
            default:         ctl.imm_data = 1'b0; // op, branch
        endcase
    end

    always_comb begin
        case (opcode[6:2])
            OPC_OP_IMM[6:2]: ctl.alu_mode = ALU_IMM;
            OPC_OP[6:2]:     ctl.alu_mode = ALU_REG;
            OPC_BRANCH[6:2]: ctl.alu_mode = ALU_BRANCH;
            default:         ctl.alu_mode = ALU_ADD; // addresses, lui, auipc
        endcase
    end

    always_comb begin
        case (opcode[6:2])
            OPC_JAL[6:2]:  {ctl.branch, ctl.wb_pc} = 2'b11;
            OPC_JALR[6:2]: {ctl.branch, ctl.wb_pc} = 2'b11;
            default:       {ctl.branch, ctl.wb_pc} = 2'b00; // branch uses cond_b
        endcase
    end

    // lui and auipc decode never overlap
    always_comb begin
        assert (ctl.op1_sel != 2'b11)
            else $error("op1_sel took unused encoding for opcode %h", opcode);
    end

endmodule

`default_nettype wire

/* hdl/imm_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module imm_gen import rv_pkg::*; (
    input  instr_u instr,
    output word_t  imm
);

    always_comb begin
        case (instr.r_fmt.opcode)
            OPC_JAL: begin
                imm = {{12{instr.j_fmt.imm_20}},
                       instr.j_fmt.imm_19_12,
                       instr.j_fmt.imm_11,
                       instr.j_fmt.imm_10_1,
                       1'b0};
            end
            OPC_BRANCH: begin
                imm = {{20{instr.b_fmt.imm_12}},
                       instr.b_fmt.imm_11,
                       instr.b_fmt.imm_10_5,
                       instr.b_fmt.imm_4_1,
                       1'b0};
            end
            OPC_LUI, OPC_AUIPC: begin
                imm = {instr.u_fmt.imm_31_12, 12'b0};
            end
            OPC_STORE: begin
                imm = {{20{instr.s_fmt.imm_11_5[6]}},
                       instr.s_fmt.imm_11_5,
                       instr.s_fmt.imm_4_0};
            end
            default: begin // op-imm, load, jalr
                imm = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu import rv_pkg::*; (
    ctrl_if.exe    ctl,
    input  instr_u instr,
    input  word_t  pc,
    input  word_t  rs1_val,
    input  word_t  rs2_val,
    input  word_t  imm,
    output word_t  result,
    output logic   taken
);

    word_t      op1;
    word_t      op2;
    word_t      sum;
    word_t      sra_val;
    logic [2:0] funct3;
    logic       bit30;
    logic       sub_en;
    logic [4:0] shamt;

    assign funct3 = instr.r_fmt.funct3;
    assign bit30  = instr.r_fmt.funct7[5];
    assign sub_en = (ctl.alu_mode == ALU_REG) && bit30; // addi ignores bit 30
    assign shamt  = op2[4:0];

    always_comb begin
        case (ctl.op1_sel)
            OP1_ZERO: op1 = '0;
            OP1_PC:   op1 = pc;
            default:  op1 = rs1_val;
        endcase
    end

    assign op2     = ctl.imm_data ? imm : rs2_val;
    assign sum     = sub_en ? op1 - op2 : op1 + op2;
    assign sra_val = $signed(op1) >>> shamt; // sign bit fills from the left

    always_comb begin
        result = sum;
        if (ctl.alu_mode == ALU_IMM || ctl.alu_mode == ALU_REG) begin
            case (funct3)
                F3_ADD:  result = sum;
                F3_SLL:  result = op1 << shamt;
                F3_SLT:  result = {31'b0, $signed(op1) < $signed(op2)};
                F3_SLTU: result = {31'b0, op1 < op2};
                F3_XOR:  result = op1 ^ op2;
                F3_SR:   result = bit30 ? sra_val : op1 >> shamt;
                F3_OR:   result = op1 | op2;
                F3_AND:  result = op1 & op2;
            endcase
        end
    end

    always_comb begin
        taken = 1'b0;
        if (ctl.alu_mode == ALU_BRANCH) begin
            case (funct3)
                F3_BEQ:  taken = (rs1_val == rs2_val);
                F3_BNE:  taken = (rs1_val != rs2_val);
                F3_BLT:  taken = ($signed(rs1_val) < $signed(rs2_val));
                F3_BGE:  taken = ($signed(rs1_val) >= $signed(rs2_val));
                F3_BLTU: taken = (rs1_val < rs2_val);
                F3_BGEU: taken = (rs1_val >= rs2_val);
                default: taken = 1'b0; // reserved
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file import rv_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  reg_idx_t rs1_idx,
    input  reg_idx_t rs2_idx,
    input  reg_idx_t rd_idx,
    input  logic     rd_we,
    input  word_t    rd_val,
    output word_t    rs1_val,
    output word_t    rs2_val
);

    word_t regs [32];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && rd_idx != 5'd0) begin // x0 stays zero
            regs[rd_idx] <= rd_val;
        end
    end

    // old value on same-cycle write
    assign rs1_val = regs[rs1_idx];
    assign rs2_val = regs[rs2_idx];

    a_x0_zero: assert property (
        @(posedge clk) disable iff (!arst_n)
        (rs1_idx == 5'd0 |-> rs1_val == '0) and (rs2_idx == 5'd0 |-> rs2_val == '0)
    ) else $error("x0 read returned nonzero");

endmodule

`default_nettype wire

/* hdl/pc_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module pc_unit import rv_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    ctrl_if.seq   ctl,
    input  logic  taken,
    input  word_t imm,
    input  word_t alu_result,
    input  word_t dmem_rdata,
    output word_t pc,
    output logic  rd_we,
    output logic  mem_we,
    output word_t rd_val
);

    logic  run;
    word_t pc_plus4;
    word_t pc_target;
    word_t next_pc;

    assign pc_plus4  = pc + 32'd4;
    assign pc_target = pc + imm;

    always_comb begin
        if (ctl.jalr) begin
            next_pc = {alu_result[31:1], 1'b0};
        end else if (ctl.branch || (ctl.cond_b && taken)) begin
            next_pc = pc_target;
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            run <= 1'b0;
            pc  <= '0;
        end else begin
            run <= 1'b1; // first edge after release
            if (run) pc <= next_pc;
        end
    end

    assign rd_we  = ctl.reg_write && run;
    assign mem_we = ctl.store && run;
    assign rd_val = ctl.wb_pc      ? pc_plus4 :
                    ctl.mem_to_reg ? dmem_rdata : alu_result;

    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!arst_n) pc[1:0] == 2'b00
    ) else $error("pc not word aligned: %h", pc);

endmodule

`default_nettype wire

/* hdl/rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core import rv_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    output word_t imem_addr,
    input  word_t imem_rdata,
    output word_t dmem_addr,
    output word_t dmem_wdata,
    output logic  dmem_we,
    input  word_t dmem_rdata
);

    instr_u   instr;
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    reg_idx_t rd_idx;
    word_t    imm;
    word_t    pc;
    word_t    rs1_val;
    word_t    rs2_val;
    word_t    alu_result;
    word_t    rd_val;
    logic     taken;
    logic     rd_we;

    ctrl_if ctl ();

    assign instr   = instr_u'(imem_rdata);
    assign rs1_idx = instr.r_fmt.rs1;
    assign rs2_idx = instr.r_fmt.rs2;
    assign rd_idx  = instr.r_fmt.rd;

    assign imem_addr  = pc;
    assign dmem_addr  = alu_result;
    assign dmem_wdata = rs2_val;

    control u_control (
        .opcode (instr.r_fmt.opcode),
        .ctl    (ctl.dec)
    );

    imm_gen u_imm_gen (
        .instr (instr),
        .imm   (imm)
    );

    alu u_alu (
        .ctl     (ctl.exe),
        .instr   (instr),
        .pc      (pc),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .imm     (imm),
        .result  (alu_result),
        .taken   (taken)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs1_idx (rs1_idx),
        .rs2_idx (rs2_idx),
        .rd_idx  (rd_idx),
        .rd_we   (rd_we),
        .rd_val  (rd_val),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val)
    );

    pc_unit u_pc_unit (
        .clk        (clk),
        .arst_n     (arst_n),
        .ctl        (ctl.seq),
        .taken      (taken),
        .imm        (imm),
        .alu_result (alu_result),
        .dmem_rdata (dmem_rdata),
        .pc         (pc),
        .rd_we      (rd_we),
        .mem_we     (dmem_we),
        .rd_val     (rd_val)
    );

endmodule

`default_nettype wire

/* tests/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk; // 40 ns period
    end

    initial begin
        arst_n <= 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n <= 1'b1; // released on a falling edge
    end

endmodule

`default_nettype wire

/* tests/tb_rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core import rv_pkg::*; ();

    localparam int    PROG_LEN   = 200;
    localparam int    LAST_IDX   = PROG_LEN - 1; // self-jump slot
    localparam int    MAX_CYCLES = 1000;
    localparam word_t DATA_BASE  = 32'h0000_1000;

    logic  clk;
    logic  arst_n;
    word_t imem_addr;
    word_t imem_rdata;
    word_t dmem_addr;
    word_t dmem_wdata;
    logic  dmem_we;
    word_t dmem_rdata;

    word_t       imem [256];
    word_t       dmem [256];
    word_t       m_mem [256];
    word_t       m_regs [32];
    word_t       m_pc;
    logic [31:0] rng_state;

    tb_clock u_clock (
        .clk    (clk),
        .arst_n (arst_n)
    );

    rv_core uut (
        .clk        (clk),
        .arst_n     (arst_n),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata)
    );

    assign imem_rdata = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_addr[9:2]]; // data region is 0x1000..0x13fc

    function automatic word_t fill_word(int idx);
        word_t addr;
        addr = DATA_BASE + word_t'(idx * 4);
        return (addr * 32'h9E37_79B1) ^ 32'h5A5A_5A5A;
    endfunction

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 256; i++) begin
                dmem[i] <= fill_word(i);
            end
        end else if (dmem_we) begin
            dmem[dmem_addr[9:2]] <= dmem_wdata;
        end
    end

    function automatic logic [31:0] xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic reg_idx_t pick_reg();
        word_t v;
        v = xorshift32();
        return v[4:0];
    endfunction

    // never x1, which holds the data base
    function automatic reg_idx_t pick_rd();
        reg_idx_t r;
        r = pick_reg();
        return (r == 5'd1) ? 5'd0 : r;
    endfunction

    function automatic int pick_target(int idx);
        int span;
        span = LAST_IDX - idx;
        if (span > 8) span = 8;
        return idx + 1 + int'(xorshift32() % word_t'(span));
    endfunction

    function automatic logic [2:0] branch_f3();
        int sel;
        sel = int'(xorshift32() % 6);
        return (sel < 2) ? 3'(sel) : 3'(sel + 2); // skip 010 and 011
    endfunction

    function automatic word_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                    logic [2:0] f3, reg_idx_t rd);
        instr_u w;
        w.r_fmt = '{f7, rs2, rs1, f3, rd, OPC_OP};
        return word_t'(w);
    endfunction

    function automatic word_t enc_i(logic [6:0] opc, reg_idx_t rd, logic [2:0] f3,
                                    reg_idx_t rs1, logic [11:0] imm);
        instr_u w;
        w.i_fmt = '{imm, rs1, f3, rd, opc};
        return word_t'(w);
    endfunction

    function automatic word_t enc_s(reg_idx_t rs2, reg_idx_t rs1, logic [11:0] off);
        instr_u w;
        w.s_fmt = '{off[11:5], rs2, rs1, 3'b010, off[4:0], OPC_STORE}; // sw
        return word_t'(w);
    endfunction

    function automatic word_t enc_b(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2,
                                    logic [12:0] off);
        instr_u w;
        w.b_fmt = '{off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
        return word_t'(w);
    endfunction

    function automatic word_t enc_u(logic [6:0] opc, reg_idx_t rd, logic [19:0] imm);
        instr_u w;
        w.u_fmt = '{imm, rd, opc};
        return word_t'(w);
    endfunction

    function automatic word_t enc_j(reg_idx_t rd, logic [20:0] off);
        instr_u w;
        w.j_fmt = '{off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
        return word_t'(w);
    endfunction

    function automatic word_t random_instr(int idx);
        word_t       r;
        word_t       w;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm12;
        int          sel;
        int          tgt;
        r     = xorshift32();
        f3    = r[14:12];
        sel   = int'(xorshift32() % 10);
        tgt   = pick_target(idx);
        imm12 = r[11:0];
        case (sel)
            0: w = enc_u(OPC_LUI, pick_rd(), r[31:12]);
            1: w = enc_u(OPC_AUIPC, pick_rd(), r[31:12]);
            2: begin
                if (f3 == F3_SLL) imm12 = {7'b0, r[4:0]};
                if (f3 == F3_SR) imm12 = {1'b0, r[20], 5'b0, r[4:0]}; // srai when r[20]
                w = enc_i(OPC_OP_IMM, pick_rd(), f3, pick_reg(), imm12);
            end
            3: begin
                f7 = ((f3 == F3_ADD || f3 == F3_SR) && r[20]) ? 7'b0100000 : 7'b0;
                w  = enc_r(f7, pick_reg(), pick_reg(), f3, pick_rd());
            end
            4: w = enc_i(OPC_LOAD, pick_rd(), 3'b010, 5'd1, {2'b0, r[7:0], 2'b00});
            5, 6: w = enc_s(pick_reg(), 5'd1, {2'b0, r[7:0], 2'b00});
            7: w = enc_b(branch_f3(), pick_reg(), pick_reg(), 13'((tgt - idx) * 4));
            8: w = enc_j(pick_rd(), 21'((tgt - idx) * 4));
            default: w = enc_i(OPC_JALR, pick_rd(), 3'b000, 5'd0,
                               12'(tgt * 4) | {11'b0, r[0]}); // absolute, bit 0 noise
        endcase
        return w;
    endfunction

    task automatic build_program();
        imem[0] = enc_u(OPC_LUI, 5'd1, 20'h00001); // x1 = data base
        for (int i = 1; i < LAST_IDX; i++) begin
            imem[i] = random_instr(i);
        end
        for (int i = LAST_IDX; i < 256; i++) begin
            imem[i] = enc_j(5'd0, 21'd0);
        end
    endtask

    function automatic word_t alu_model(logic [2:0] f3, logic alt, word_t a, word_t b);
        word_t sra;
        sra = $signed(a) >>> b[4:0];
        case (f3)
            F3_ADD:  return alt ? a - b : a + b;
            F3_SLL:  return a << b[4:0];
            F3_SLT:  return {31'b0, $signed(a) < $signed(b)};
            F3_SLTU: return {31'b0, a < b};
            F3_XOR:  return a ^ b;
            F3_SR:   return alt ? sra : a >> b[4:0];
            F3_OR:   return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_model(logic [2:0] f3, word_t a, word_t b);
        case (f3)
            F3_BEQ:  return a == b;
            F3_BNE:  return a != b;
            F3_BLT:  return $signed(a) < $signed(b);
            F3_BGE:  return $signed(a) >= $signed(b);
            F3_BLTU: return a < b;
            F3_BGEU: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic model_step(output logic st, output word_t st_addr, output word_t st_data);
        word_t ins;
        word_t a;
        word_t b;
        word_t imm_i;
        word_t imm_s;
        word_t imm_b;
        word_t imm_u;
        word_t imm_j;
        word_t next_pc;
        word_t val;
        word_t ld_addr;
        logic  wr;
        ins     = imem[m_pc[9:2]];
        a       = m_regs[ins[19:15]];
        b       = m_regs[ins[24:20]];
        imm_i   = {{20{ins[31]}}, ins[31:20]};
        imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_u   = {ins[31:12], 12'b0};
        imm_j   = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        next_pc = m_pc + 32'd4;
        val     = m_pc + 32'd4; // link value
        wr      = 1'b1;
        st      = 1'b0;
        st_addr = '0;
        st_data = '0;
        ld_addr = a + imm_i;
        case (ins[6:0])
            OPC_LUI:    val = imm_u;
            OPC_AUIPC:  val = m_pc + imm_u;
            OPC_JAL:    next_pc = m_pc + imm_j;
            OPC_JALR:   next_pc = ld_addr & ~32'd1;
            OPC_LOAD:   val = m_mem[ld_addr[9:2]];
            OPC_OP_IMM: val = alu_model(ins[14:12], ins[30] && ins[14:12] == F3_SR, a, imm_i);
            OPC_OP:     val = alu_model(ins[14:12], ins[30], a, b);
            OPC_BRANCH: begin
                wr = 1'b0;
                if (branch_model(ins[14:12], a, b)) next_pc = m_pc + imm_b;
            end
            OPC_STORE: begin
                wr      = 1'b0;
                st      = 1'b1;
                st_addr = a + imm_s;
                st_data = b;
            end
            default: wr = 1'b0;
        endcase
        if (wr && ins[11:7] != 5'd0) m_regs[ins[11:7]] = val;
        if (st) m_mem[st_addr[9:2]] = st_data;
        m_pc = next_pc;
    endtask

    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_pc(input word_t exp, input word_t got);
        if (got !== exp) begin
            $display("MISMATCH imem_addr exp=%h got=%h", exp, got);
            abort_run();
        end
    endtask

    task automatic check_store(input word_t exp_addr, input word_t got_addr,
                               input word_t exp_data, input word_t got_data);
        if (got_addr !== exp_addr) begin
            $display("MISMATCH dmem_addr exp=%h got=%h", exp_addr, got_addr);
            abort_run();
        end
        if (got_data !== exp_data) begin
            $display("MISMATCH dmem_wdata exp=%h got=%h", exp_data, got_data);
            abort_run();
        end
    endtask

    task automatic check_we(input logic exp, input logic got);
        if (got !== exp) begin
            $display("MISMATCH dmem_we exp=%h got=%h", exp, got);
            abort_run();
        end
    endtask

    initial begin
        int    waited;
        int    cycles;
        logic  done;
        logic  st;
        word_t st_addr;
        word_t st_data;
        rng_state = 32'd86;
        build_program();
        for (int i = 0; i < 256; i++) begin
            m_mem[i] = fill_word(i);
        end
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = '0;
        end
        m_pc   = '0;
        waited = 0;
        @(negedge clk);
        while (!arst_n && waited < 20) begin
            check_pc(32'h0, imem_addr); // held at 0 during reset
            check_we(1'b0, dmem_we);
            @(negedge clk);
            waited++;
        end
        if (!arst_n) begin
            $display("reset was never released");
            abort_run();
        end
        done   = 1'b0;
        cycles = 0;
        while (!done && cycles < MAX_CYCLES) begin
            check_pc(m_pc, imem_addr);
            done = (m_pc == word_t'(LAST_IDX * 4));
            model_step(st, st_addr, st_data);
            check_we(st, dmem_we);
            if (st) check_store(st_addr, dmem_addr, st_data, dmem_wdata);
            if (!done) begin
                @(negedge clk);
                cycles++;
            end
        end
        if (done) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("program never reached the final self-jump within %0d cycles", MAX_CYCLES);
            abort_run();
        end
    end

endmodule

`default_nettype wire

/* flist.f */
hdl/rv_pkg.sv
hdl/ctrl_if.sv
hdl/control.sv
hdl/imm_gen.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/pc_unit.sv
hdl/rv_core.sv
tests/tb_clock.sv
tests/tb_rv_core.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f flist.f --top-module tb_rv_core -o tb_rv_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_rv_core)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "Finished with no errors"; then
    exit 0
fi
echo "pass message not found"
exit 1
